// ==== sources.f ====
+incdir+design
design/resize_pkg.sv
design/pipe_delay.sv
design/coord_scan.sv
design/src_addr_gen.sv
design/bilinear_mac.sv
design/resize_top.sv
tb/tb_clock.sv
tb/tb_resize.sv

// ==== Bender.yml ====
package:
  name: resize

sources:
  - include_dirs:
      - design
    files:
      - design/resize_pkg.sv
      - design/pipe_delay.sv
      - design/coord_scan.sv
      - design/src_addr_gen.sv
      - design/bilinear_mac.sv
      - design/resize_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_clock.sv
      - tb/tb_resize.sv

// ==== tb/tb_resize.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "resize_config.svh"

module tb_resize;

  localparam int SRC_W         = `RESIZE_SRC_W;
  localparam int SRC_H         = `RESIZE_SRC_H;
  localparam int DST_W         = `RESIZE_DST_W;
  localparam int DST_H         = `RESIZE_DST_H;
  localparam int FB            = `RESIZE_FRAC_BITS;
  localparam int NUM_PIX       = DST_W * DST_H;
  localparam int NUM_TESTS     = 5;
  localparam int FRAME_TIMEOUT = 4 * NUM_PIX + 50;
  localparam int KIND_CONST    = 0;
  localparam int KIND_RAMP     = 1;
  localparam int KIND_RANDOM   = 2;

  logic               clk;
  logic               rst_n;
  logic               start;
  resize_pkg::pixel_t rd_data_a;
  resize_pkg::pixel_t rd_data_b;
  resize_pkg::addr_t  rd_addr_a;
  resize_pkg::addr_t  rd_addr_b;
  logic               rd_en;
  logic               wr_en;
  resize_pkg::addr_t  wr_addr;
  resize_pkg::pixel_t wr_data;
  logic               done;

  // pattern kind, parameter, expected number of writes
  int test_kind  [NUM_TESTS] = '{KIND_CONST, KIND_CONST, KIND_RAMP, KIND_RANDOM, KIND_RANDOM};
  int test_param [NUM_TESTS] = '{77, 255, 19, 39410, 39410};
  int test_count [NUM_TESTS] = '{NUM_PIX, NUM_PIX, NUM_PIX, NUM_PIX, NUM_PIX};

  resize_pkg::pixel_t src_mem [SRC_W * SRC_H];
  resize_pkg::pixel_t first_random [NUM_PIX];
  logic               have_random;
  logic [15:0]        lfsr_state;
  int                 error_count;
  int                 check_count;

  tb_clock #(.PERIOD(40), .RESET_CYCLES(16)) u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  resize_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_en     (rd_en),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .done      (done)
  );

  // two read ports with one cycle of latency
  always @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_data_a <= src_mem[rd_addr_a];
      rd_data_b <= src_mem[rd_addr_b];
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state >> 1;
    if (state[0])
    begin
      lfsr_next = lfsr_next ^ 16'hB400;
    end
  endfunction

  task automatic fill_image(input int kind, input int param);
    resize_pkg::pixel_t value;
    value      = '0;
    lfsr_state = param[15:0];
    for (int a = 0; a < SRC_W * SRC_H; a++)
    begin
      case (kind)
        KIND_CONST:
        begin
          value = param[7:0];
        end
        KIND_RAMP:
        begin
          value = 8'((a % SRC_W) * param);
        end
        default:
        begin
          // one lfsr step per bit
          for (int b = 0; b < 8; b++)
          begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
          end
        end
      endcase
      src_mem[a] = value;
    end
  endtask

  // source address read on port a or port b
  function automatic int window_addr(input int read_idx, input int right);
    int     x;
    int     y;
    longint ix;
    longint iy;
    x  = (read_idx / 2) % DST_W + 1;
    y  = (read_idx / 2) / DST_W + 1;
    ix = (longint'(x) * `RESIZE_SCALE_X) >> FB;
    iy = (longint'(y) * `RESIZE_SCALE_Y) >> FB;
    // even reads fetch the upper row
    return int'((iy - 1 + read_idx % 2) * SRC_W + ix - 1 + right);
  endfunction

  // truncated bilinear blend of the 2x2 window
  function automatic int model_pixel(input int x, input int y);
    longint one;
    longint sx;
    longint sy;
    longint ix;
    longint iy;
    longint fx;
    longint fy;
    longint acc;
    one = longint'(1) << FB;
    sx  = longint'(x) * `RESIZE_SCALE_X;
    sy  = longint'(y) * `RESIZE_SCALE_Y;
    ix  = sx >> FB;
    iy  = sy >> FB;
    fx  = sx & (one - 1);
    fy  = sy & (one - 1);
    acc = (one - fx) * (one - fy) * src_mem[(iy - 1) * SRC_W + ix - 1]
        + fx * (one - fy) * src_mem[(iy - 1) * SRC_W + ix]
        + (one - fx) * fy * src_mem[iy * SRC_W + ix - 1]
        + fx * fy * src_mem[iy * SRC_W + ix];
    return int'(acc >> (2 * FB));
  endfunction

  task automatic run_test(input int t);
    int   writes;
    int   reads;
    int   cycles;
    int   last_wr;
    int   errors_before;
    logic finished;
    writes        = 0;
    reads         = 0;
    cycles        = 0;
    last_wr       = -1;
    finished      = 1'b0;
    errors_before = error_count;
    fill_image(test_kind[t], test_param[t]);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!finished && cycles < FRAME_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (rd_en)
      begin
        if (reads < 2 * NUM_PIX)
        begin
          check_value("read address a", rd_addr_a, window_addr(reads, 0));
          check_value("read address b", rd_addr_b, window_addr(reads, 1));
        end
        reads++;
      end
      if (wr_en)
      begin
        // raster order without gaps or repeats
        check_value("write address", wr_addr, writes);
        if (writes < NUM_PIX)
        begin
          check_value("pixel", wr_data, model_pixel(writes % DST_W + 1, writes / DST_W + 1));
          if (test_kind[t] == KIND_CONST)
          begin
            check_value("constant pixel", wr_data, test_param[t]);
          end
          if (test_kind[t] == KIND_RANDOM)
          begin
            if (have_random)
            begin
              check_value("repeated frame pixel", wr_data, first_random[writes]);
            end
            else
            begin
              first_random[writes] = wr_data;
            end
          end
        end
        writes++;
        last_wr = cycles;
      end
      if (done)
      begin
        check_value("done cycle", cycles, last_wr + 1);
        finished = 1'b1;
      end
    end
    if (!finished)
    begin
      $display("timeout: no done within %0d cycles of start in test %0d", FRAME_TIMEOUT, t);
      $display("test failed");
      $finish;
    end
    // quiet until the next start
    for (int i = 0; i < 12; i++)
    begin
      @(negedge clk);
      check_value("wr_en after done", wr_en, 0);
      check_value("second done", done, 0);
    end
    check_value("read count", reads, 2 * NUM_PIX);
    check_value("write count", writes, test_count[t]);
    if (test_kind[t] == KIND_RANDOM)
    begin
      have_random = 1'b1;
    end
    $display("test %0d kind %0d param %0d: %0d writes, %s", t, test_kind[t], test_param[t],
             writes, (error_count == errors_before) ? "ok" : "mismatch");
  endtask

  initial
  begin
    int wait_cycles;
    start       = 1'b0;
    rd_data_a   = '0;
    rd_data_b   = '0;
    have_random = 1'b0;
    lfsr_state  = 16'd39410;
    error_count = 0;
    check_count = 0;
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 100)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("reset was never released");
      $display("test failed");
      $finish;
    end
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      check_value("rd_en while idle", rd_en, 0);
      check_value("wr_en while idle", wr_en, 0);
      check_value("done while idle", done, 0);
    end
    $display("reset idle: %0d errors", error_count);
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released on a rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/resize_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "resize_config.svh"

module resize_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               start,
  input  wire resize_pkg::pixel_t rd_data_a,
  input  wire resize_pkg::pixel_t rd_data_b,
  output resize_pkg::addr_t       rd_addr_a,
  output resize_pkg::addr_t       rd_addr_b,
  output logic                    rd_en,
  output logic                    wr_en,
  output resize_pkg::addr_t       wr_addr,
  output resize_pkg::pixel_t      wr_data,
  output logic                    done
);

  // phase-0 cycle of a pixel to its write
  localparam int WR_DEPTH = 7;

  localparam resize_pkg::addr_t DST_W = resize_pkg::addr_t'(`RESIZE_DST_W);

  resize_pkg::coord_t x;
  resize_pkg::coord_t y;
  logic               phase;
  logic               active;
  logic               last;

  resize_pkg::frac_t       fx;
  resize_pkg::frac_t       fy;
  resize_pkg::frac_t [1:0] frac_in;
  resize_pkg::frac_t [1:0] frac_out;
  logic                    rd_phase;
  logic                    capture_top;
  logic                    compute;

  resize_pkg::addr_t dst_addr;
  logic [1:0]        flags_in;
  logic [1:0]        flags_out;

  coord_scan u_scan (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .x      (x),
    .y      (y),
    .phase  (phase),
    .active (active),
    .last   (last)
  );

  src_addr_gen u_addr (
    .clk       (clk),
    .rst_n     (rst_n),
    .x         (x),
    .y         (y),
    .phase     (phase),
    .valid     (active),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .fx        (fx),
    .fy        (fy),
    .rd_en     (rd_en),
    .rd_phase  (rd_phase)
  );

  // fractions wait for the phase-1 data
  assign frac_in = {fy, fx};

  pipe_delay #(
    .DEPTH     (1),
    .payload_t (resize_pkg::frac_t [1:0])
  ) u_frac_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (frac_in),
    .dout  (frac_out)
  );

  assign capture_top = rd_en & ~rd_phase;
  assign compute     = rd_en & rd_phase;

  bilinear_mac u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .top_a       (rd_data_a),
    .top_b       (rd_data_b),
    .bot_a       (rd_data_a),
    .bot_b       (rd_data_b),
    .fx          (frac_out[0]),
    .fy          (frac_out[1]),
    .capture_top (capture_top),
    .compute     (compute),
    .pixel       (wr_data)
  );

  assign dst_addr = resize_pkg::addr_t'(x - 1'b1) + resize_pkg::addr_t'(y - 1'b1) * DST_W;

  pipe_delay #(
    .DEPTH     (WR_DEPTH),
    .payload_t (resize_pkg::addr_t)
  ) u_addr_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (dst_addr),
    .dout  (wr_addr)
  );

  // write tagged on phase 0, last one cycle later so done trails the final write
  assign flags_in = {active & ~phase & ~start, last};

  pipe_delay #(
    .DEPTH     (WR_DEPTH),
    .payload_t (logic [1:0])
  ) u_flag_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (flags_in),
    .dout  (flags_out)
  );

  assign wr_en = flags_out[1];
  assign done  = flags_out[0];

endmodule

`default_nettype wire

// ==== design/bilinear_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

module bilinear_mac (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire resize_pkg::pixel_t top_a,
  input  wire resize_pkg::pixel_t top_b,
  input  wire resize_pkg::pixel_t bot_a,
  input  wire resize_pkg::pixel_t bot_b,
  input  wire resize_pkg::frac_t  fx,
  input  wire resize_pkg::frac_t  fy,
  input  wire logic               capture_top,
  input  wire logic               compute,
  output resize_pkg::pixel_t      pixel
);

  localparam int FB    = $bits(resize_pkg::frac_t);
  localparam int ACC_W = $bits(resize_pkg::acc_t);
  localparam int PIX_W = $bits(resize_pkg::pixel_t);

  // 1.0 in fraction units
  localparam logic [FB:0] ONE = {1'b1, {FB{1'b0}}};

  // strobes come with the read address, data lands one cycle later
  logic capture_q;
  logic compute_q;

  resize_pkg::pixel_t top_a_q;
  resize_pkg::pixel_t top_b_q;

  logic [FB:0] fx_w;
  logic [FB:0] fy_w;
  logic [FB:0] fx_c;
  logic [FB:0] fy_c;

  resize_pkg::weight_t w00, w01, w10, w11;
  resize_pkg::pixel_t  p00, p01, p10, p11;
  resize_pkg::acc_t    m00, m01, m10, m11;
  resize_pkg::acc_t    sum_top;
  resize_pkg::acc_t    sum_bot;
  resize_pkg::acc_t    total;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      capture_q <= 1'b0;
      compute_q <= 1'b0;
    end
    else
    begin
      capture_q <= capture_top;
      compute_q <= compute;
    end
  end

  // upper row from phase 0
  always_ff @(posedge clk)
  begin
    if (capture_q)
    begin
      top_a_q <= top_a;
      top_b_q <= top_b;
    end
  end

  assign fx_w = {1'b0, fx};
  assign fy_w = {1'b0, fy};
  assign fx_c = ONE - fx_w;
  assign fy_c = ONE - fy_w;

  // weights, fractions never both zero with these scale factors
  always_ff @(posedge clk)
  begin
    if (compute_q)
    begin
      w00 <= fx_c * fy_c;
      w01 <= fx_w * fy_c;
      w10 <= fx_c * fy_w;
      w11 <= fx_w * fy_w;
      p00 <= top_a_q;
      p01 <= top_b_q;
      p10 <= bot_a;
      p11 <= bot_b;
    end
  end

  always_ff @(posedge clk)
  begin
    m00     <= w00 * p00;
    m01     <= w01 * p01;
    m10     <= w10 * p10;
    m11     <= w11 * p11;
    sum_top <= m00 + m01;
    sum_bot <= m10 + m11;
  end

  // drop the 24 weight bits, no rounding
  assign total = sum_top + sum_bot;
  assign pixel = total[ACC_W-1 -: PIX_W];

endmodule

`default_nettype wire

// ==== design/src_addr_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "resize_config.svh"

module src_addr_gen (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire resize_pkg::coord_t x,
  input  wire resize_pkg::coord_t y,
  input  wire logic               phase,
  input  wire logic               valid,
  output resize_pkg::addr_t       rd_addr_a,
  output resize_pkg::addr_t       rd_addr_b,
  output resize_pkg::frac_t       fx,
  output resize_pkg::frac_t       fy,
  output logic                    rd_en,
  output logic                    rd_phase
);

  localparam int FB    = `RESIZE_FRAC_BITS;
  localparam int FIX_W = $bits(resize_pkg::fix_coord_t);
  localparam int INT_W = FIX_W - FB;

  localparam resize_pkg::fix_coord_t SCALE_X = resize_pkg::fix_coord_t'(`RESIZE_SCALE_X);
  localparam resize_pkg::fix_coord_t SCALE_Y = resize_pkg::fix_coord_t'(`RESIZE_SCALE_Y);
  localparam resize_pkg::addr_t      SRC_W   = resize_pkg::addr_t'(`RESIZE_SRC_W);

  resize_pkg::fix_coord_t sx_q;
  resize_pkg::fix_coord_t sy_q;
  logic                   valid_q;
  logic                   phase_q;

  logic [INT_W-1:0]  ix;
  logic [INT_W-1:0]  iy;
  logic [INT_W-1:0]  row;
  resize_pkg::addr_t row_base;

  // stage 1: scaled coordinates
  always_ff @(posedge clk)
  begin
    sx_q <= resize_pkg::fix_coord_t'(x) * SCALE_X;
    sy_q <= resize_pkg::fix_coord_t'(y) * SCALE_Y;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      phase_q <= 1'b0;
    end
    else
    begin
      valid_q <= valid;
      phase_q <= phase;
    end
  end

  assign ix = sx_q[FIX_W-1:FB];
  assign iy = sy_q[FIX_W-1:FB];

  // upper row in phase 0, lower row in phase 1
  assign row      = phase_q ? iy : iy - 1'b1;
  assign row_base = resize_pkg::addr_t'(row) * SRC_W;

  // stage 2: left and right columns of the 2x2 window
  always_ff @(posedge clk)
  begin
    rd_addr_a <= row_base + resize_pkg::addr_t'(ix) - 1'b1;
    rd_addr_b <= row_base + resize_pkg::addr_t'(ix);
    fx        <= sx_q[FB-1:0];
    fy        <= sy_q[FB-1:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_en    <= 1'b0;
      rd_phase <= 1'b0;
    end
    else
    begin
      rd_en    <= valid_q;
      rd_phase <= phase_q;
    end
  end

endmodule

`default_nettype wire

// ==== design/coord_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "resize_config.svh"

module coord_scan (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         start,
  output resize_pkg::coord_t x,
  output resize_pkg::coord_t y,
  output logic              phase,
  output logic              active,
  output logic              last
);

  localparam resize_pkg::coord_t LAST_X = resize_pkg::coord_t'(`RESIZE_DST_W);
  localparam resize_pkg::coord_t LAST_Y = resize_pkg::coord_t'(`RESIZE_DST_H);

  logic end_of_row;
  logic end_of_frame;

  assign end_of_row   = (x == LAST_X);
  assign end_of_frame = end_of_row && (y == LAST_Y);

  // phase 1 of the bottom-right pixel
  assign last = active && phase && end_of_frame;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x      <= '0;
      y      <= '0;
      phase  <= 1'b0;
      active <= 1'b0;
    end
    else if (start)
    begin
      // restart from the top-left corner, also mid-frame
      x      <= resize_pkg::coord_t'(1);
      y      <= resize_pkg::coord_t'(1);
      phase  <= 1'b0;
      active <= 1'b1;
    end
    else if (active)
    begin
      phase <= ~phase;
      // advance only once both source rows are read
      if (phase)
      begin
        if (!end_of_row)
        begin
          x <= x + 1'b1;
        end
        else if (!end_of_frame)
        begin
          x <= resize_pkg::coord_t'(1);
          y <= y + 1'b1;
        end
        else
        begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pipe_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_delay #(
  parameter int  DEPTH     = 1,
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire payload_t din,
  output payload_t      dout
);

  payload_t stage_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= din;
      for (int i = 1; i < DEPTH; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/resize_pkg.sv ====
`default_nettype none

`include "resize_config.svh"

package resize_pkg;

  // 8-bit grey level
  typedef logic [7:0] pixel_t;

  // linear address into source or destination image
  typedef logic [`RESIZE_ADDR_W-1:0] addr_t;

  // one-based destination coordinate
  typedef logic [9:0] coord_t;

  // coordinate times scale, integer part above the fraction bits
  typedef logic [22:0] fix_coord_t;

  typedef logic [`RESIZE_FRAC_BITS-1:0] frac_t;

  // product of two complementary fractions
  typedef logic [23:0] weight_t;

  // weight times pixel and the sums of those
  typedef logic [31:0] acc_t;

endpackage

`default_nettype wire

// ==== design/resize_config.svh ====
`ifndef RESIZE_CONFIG_SVH
`define RESIZE_CONFIG_SVH

// reduced frame, full-size pyramid stage is 640 x 480 -> 533 x 400
`define RESIZE_SRC_W 13
`define RESIZE_SRC_H 11
`define RESIZE_DST_W 10
`define RESIZE_DST_H 8

// source pixels per destination pixel, 12 fraction bits
`define RESIZE_SCALE_X 4918
`define RESIZE_SCALE_Y 4915
`define RESIZE_FRAC_BITS 12

// floor(DST_W * SCALE_X) >> FRAC_BITS must stay within SRC_W - 1, same for rows
`define RESIZE_ADDR_W 19

`endif
